// File: Bender.yml
package:
  name: i2si

sources:
  - target: any(design, tb)
    files:
      - design/i2si_pkg.sv
      - design/i2si_sck_sync.sv
      - design/i2si_bist_gen.sv
      - design/i2si_lane.sv
      - design/i2si_collect.sv
      - design/i2si_top.sv
  - target: tb
    files:
      - tb/i2si_assert.sv
      - tb/i2si_checker.sv
      - tb/i2si_tb.sv

// File: design/i2si_bist_gen.sv
module i2si_bist_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sck_transition,
    input  logic                   ws_s,
    input  i2si_pkg::bist_cfg_t    cfg,
    output i2si_pkg::lane_word_t   bist_word,
    output logic                   bist_xfc
);

    import i2si_pkg::*;

    logic             ws_last;                  // ws at the previous bit
    logic             ws_seen;                  // ws_last holds a real sample
    logic             slot_end;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W:0]   sum;                      // one extra bit for overflow
    logic [CNT_W-1:0] cnt_nxt;

    // a ws change closes the current slot, same as for real data
    assign slot_end = sck_transition && ws_seen && (ws_s != ws_last);

    assign sum = {1'b0, cnt} + (CNT_W + 1)'(cfg.inc);
    assign cnt_nxt = (sum > {1'b0, cfg.up_limit}) ? cfg.start_val : sum[CNT_W-1:0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ws_last <= 1'b0;
            ws_seen <= 1'b0;
            cnt <= '0;
            bist_xfc <= 1'b0;
        end
        else
        begin
            if (sck_transition)
            begin
                ws_last <= ws_s;
                ws_seen <= 1'b1;
            end
            // held at the start value so a new enable restarts the sequence
            if (!cfg.enable)
            begin
                cnt <= cfg.start_val;
            end
            else if (slot_end)
            begin
                cnt <= cnt_nxt;
            end
            bist_xfc <= slot_end & cfg.enable;  // 1 clk after the closing strobe
        end
    end

    always_ff @(posedge clk)
    begin
        if (slot_end)
        begin
            bist_word.data <= WORD_W'(cnt);     // zero extended count
            bist_word.channel <= ws_last;       // slot belonged to old ws
        end
    end

endmodule

// File: design/i2si_collect.sv
module i2si_collect (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  i2si_pkg::lane_word_t                 word [i2si_pkg::NUM_LANES],
    input  logic [i2si_pkg::NUM_LANES-1:0]       word_valid,
    output i2si_pkg::out_word_t                  out_word,
    output logic                                 out_xfc
);

    import i2si_pkg::*;

    lane_word_t           hold [NUM_LANES];     // one waiting word per lane
    logic [NUM_LANES-1:0] pend;
    logic [LANE_W-1:0]    ptr;                  // lane after the last one served
    logic [LANE_W-1:0]    idx;
    logic [LANE_W-1:0]    sel;
    logic                 found;

    // first pending lane at or after ptr
    always_comb
    begin
        sel = ptr;
        found = 1'b0;
        idx = ptr;
        for (int k = 0; k < NUM_LANES; k++)
        begin
            idx = LANE_W'((int'(ptr) + k) % NUM_LANES);
            if (!found && pend[idx])
            begin
                sel = idx;
                found = 1'b1;
            end
        end
    end

    assign out_xfc = found;
    assign out_word.data = hold[sel].data;
    assign out_word.channel = hold[sel].channel;
    assign out_word.lane = sel;

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (word_valid[i])
            begin
                hold[i] <= word[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend <= '0;
            ptr <= '0;
        end
        else
        begin
            if (found)
            begin
                ptr <= LANE_W'((int'(sel) + 1) % NUM_LANES);
            end
            for (int i = 0; i < NUM_LANES; i++)
            begin
                if (word_valid[i])
                begin
                    pend[i] <= 1'b1;            // new word wins over a clear
                end
                else if (found && (sel == LANE_W'(i)))
                begin
                    pend[i] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: design/i2si_lane.sv
module i2si_lane (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sck_transition,
    input  logic                   ws_s,
    input  logic                   sd,
    input  i2si_pkg::bist_cfg_t    cfg,
    output i2si_pkg::lane_word_t   word,
    output logic                   word_valid
);

    import i2si_pkg::*;

    logic [2:0]           sd_dly;               // matches the sck/ws sync path
    logic                 sd_bit;
    logic                 ws_last;
    logic                 ws_seen;
    logic                 framed;               // a slot boundary has been seen
    logic                 ws_change;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [WORD_W-1:0]    shift_q;
    logic [WORD_W-1:0]    shift_nxt;
    lane_word_t           data_word;
    logic                 data_valid;
    lane_word_t           bist_word;
    logic                 bist_xfc;

    i2si_bist_gen u_bist_gen (
        .clk            (clk),
        .rst_n          (rst_n),
        .sck_transition (sck_transition),
        .ws_s           (ws_s),
        .cfg            (cfg),
        .bist_word      (bist_word),
        .bist_xfc       (bist_xfc)
    );

    assign sd_bit = sd_dly[2];
    assign ws_change = ws_seen && (ws_s != ws_last);

    // msb first, left justified, bits past a full slot are dropped
    always_comb
    begin
        shift_nxt = shift_q;
        if (bit_cnt < BITS_PER_CH)
        begin
            shift_nxt[WORD_W - 1 - int'(bit_cnt)] = sd_bit;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sd_dly <= '0;
            ws_last <= 1'b0;
            ws_seen <= 1'b0;
            framed <= 1'b0;
            bit_cnt <= '0;
            data_valid <= 1'b0;
        end
        else
        begin
            sd_dly <= {sd_dly[1:0], sd};
            data_valid <= 1'b0;
            if (sck_transition)
            begin
                ws_last <= ws_s;
                ws_seen <= 1'b1;
                if (ws_change)
                begin
                    framed <= 1'b1;
                    bit_cnt <= '0;              // next bit is the msb
                    data_valid <= framed;       // first slot after reset is partial
                end
                else if (bit_cnt < BITS_PER_CH)
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (sck_transition)
        begin
            if (ws_change)
            begin
                shift_q <= '0;
                data_word.data <= shift_nxt;    // includes the lsb taken now
                data_word.channel <= ws_last;
            end
            else
            begin
                shift_q <= shift_nxt;
            end
        end
    end

    // test mode replaces the serial data
    assign word = cfg.enable ? bist_word : data_word;
    assign word_valid = cfg.enable ? bist_xfc : data_valid;

endmodule

// File: design/i2si_pkg.sv
package i2si_pkg;

    // lane count and numbering
    localparam int NUM_LANES = 4;
    localparam int LANE_W = 2;                  // enough to number every lane

    // serial framing
    localparam int WORD_W = 32;                 // width of one channel word
    localparam int BITS_PER_CH = 32;            // serial bits in one ws slot
    localparam int BIT_CNT_W = $clog2(BITS_PER_CH + 1); // counts 0 up to a full slot

    // test pattern generator
    localparam int CNT_W = 12;                  // counter width
    localparam int INC_W = 8;                   // step width

    // test configuration, static while a test runs
    typedef struct packed {
        logic             enable;               // 1 selects the counting pattern
        logic [CNT_W-1:0] start_val;            // first value and wrap target
        logic [INC_W-1:0] inc;                  // added after every word
        logic [CNT_W-1:0] up_limit;             // highest value before wrapping
    } bist_cfg_t;

    // one finished word from a lane
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              channel;             // 0 left, 1 right
    } lane_word_t;

    // word on the collected output stream
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              channel;             // 0 left, 1 right
        logic [LANE_W-1:0] lane;                // source lane
    } out_word_t;

endpackage

// File: design/i2si_sck_sync.sv
module i2si_sck_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic sck,
    input  logic ws,
    output logic sck_transition,
    output logic ws_s
);

    logic sck_meta;                             // first sync stage
    logic sck_sync;                             // second sync stage
    logic sck_dly;                              // previous synced sck
    logic ws_meta;
    logic ws_sync;
    logic sck_rise;

    // rising edge of the synchronized bit clock
    assign sck_rise = sck_sync & ~sck_dly;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_meta <= 1'b0;
            sck_sync <= 1'b0;
            sck_dly <= 1'b0;
            ws_meta <= 1'b0;
            ws_sync <= 1'b0;
        end
        else
        begin
            sck_meta <= sck;
            sck_sync <= sck_meta;
            sck_dly <= sck_sync;
            ws_meta <= ws;                      // same two stages as sck
            ws_sync <= ws_meta;
        end
    end

    // strobe and ws leave together, 3 clk after the sck edge
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sck_transition <= 1'b0;
            ws_s <= 1'b0;
        end
        else
        begin
            sck_transition <= sck_rise;
            if (sck_rise)
            begin
                ws_s <= ws_sync;                // ws as seen at that edge
            end
        end
    end

endmodule

// File: design/i2si_top.sv
module i2si_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             sck,
    input  logic                             ws,
    input  logic [i2si_pkg::NUM_LANES-1:0]   sd,
    input  i2si_pkg::bist_cfg_t              cfg,
    output i2si_pkg::out_word_t              out_word,
    output logic                             out_xfc
);

    import i2si_pkg::*;

    logic                 sck_transition;       // shared by every lane
    logic                 ws_s;
    lane_word_t           lane_word [NUM_LANES];
    logic [NUM_LANES-1:0] lane_valid;

    i2si_sck_sync u_sck_sync (
        .clk            (clk),
        .rst_n          (rst_n),
        .sck            (sck),
        .ws             (ws),
        .sck_transition (sck_transition),
        .ws_s           (ws_s)
    );

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_lane
        i2si_lane u_lane (
            .clk            (clk),
            .rst_n          (rst_n),
            .sck_transition (sck_transition),
            .ws_s           (ws_s),
            .sd             (sd[i]),
            .cfg            (cfg),
            .word           (lane_word[i]),
            .word_valid     (lane_valid[i])
        );
    end

    // all lanes merge into one stream
    i2si_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .word       (lane_word),
        .word_valid (lane_valid),
        .out_word   (out_word),
        .out_xfc    (out_xfc)
    );

endmodule

// File: list.f
design/i2si_pkg.sv
design/i2si_sck_sync.sv
design/i2si_bist_gen.sv
design/i2si_lane.sv
design/i2si_collect.sv
design/i2si_top.sv
tb/i2si_assert.sv
tb/i2si_checker.sv
tb/i2si_tb.sv

// File: tb/i2si_assert.sv
module i2si_assert (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             sck,
    input logic                             sck_transition,
    input logic [i2si_pkg::NUM_LANES-1:0]   lane_valid,
    input i2si_pkg::out_word_t              out_word,
    input logic                             out_xfc
);
    timeunit 1ns;
    timeprecision 100ps;

    import i2si_pkg::*;

    // two sync flops and the edge register sit between sck and the lanes
    a_strobe_delay: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sck) |-> ##3 sck_transition)
        else $error("sck_transition missing 3 clk after a rising sck");

    // every lane word leaves within one round of the pointer
    for (genvar i = 0; i < NUM_LANES; i++)
    begin : g_served
        a_served: assert property (@(posedge clk) disable iff (!rst_n)
            lane_valid[i] |-> ##[1:NUM_LANES] (out_xfc && out_word.lane == LANE_W'(i)))
            else $error("lane %0d word not passed to the output in time", i);
    end

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_xfc)
        else $error("out_xfc high while in reset");

endmodule

bind i2si_top i2si_assert u_assert (.*);

// File: tb/i2si_checker.sv
module i2si_checker (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             sck,
    input logic                             ws,
    input logic [i2si_pkg::NUM_LANES-1:0]   sd,
    input i2si_pkg::bist_cfg_t              cfg,
    input i2si_pkg::out_word_t              out_word,
    input logic                             out_xfc
);
    timeunit 1ns;
    timeprecision 100ps;

    import i2si_pkg::*;

    out_word_t            exp_q [$];            // expected words of all lanes
    string                test_name = "startup";
    int                   pending = 0;
    int                   test_errors = 0;
    int                   words_seen = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;
    logic [WORD_W-1:0]    last_data [NUM_LANES]; // previous output word per lane
    logic [NUM_LANES-1:0] last_ok;
    logic [NUM_LANES-1:0] wrapped;              // lane came back to start_val
    logic                 sck_q;
    logic                 ws_last;
    logic                 ws_seen;
    logic                 framed;               // a slot boundary was seen
    int                   bit_cnt;
    logic [CNT_W-1:0]     cnt;
    logic [WORD_W-1:0]    shift [NUM_LANES];

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
        words_seen = 0;
        last_ok = '0;
        wrapped = '0;
    endtask

    task automatic note_failure(input string what);
        $display("test %s: %s", test_name, what);
        test_errors++;
    endtask

    task automatic finish_test();
        if (pending != 0)
            note_failure($sformatf("%0d expected words never came out", pending));
        tests_run++;
        if (test_errors == 0)
            $display("test %s: passed, %0d words checked", test_name, words_seen);
        else
        begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic push_word(input logic [WORD_W-1:0] data, input logic ch, input int lane);
        out_word_t w;
        w.data = data;
        w.channel = ch;
        w.lane = LANE_W'(lane);
        exp_q.push_back(w);
        pending++;
    endtask

    // oldest expected word of the same lane
    task automatic check_word(input out_word_t got);
        int idx;
        idx = -1;
        for (int k = 0; k < exp_q.size(); k++)
            if (idx < 0 && exp_q[k].lane == got.lane)
                idx = k;
        if (idx < 0)
            note_failure($sformatf("unexpected word from lane %0d", got.lane));
        else
        begin
            if (exp_q[idx].data !== got.data || exp_q[idx].channel !== got.channel)
            begin
                $display("error: test %s lane %0d expected %h ch %0d actual %h ch %0d",
                         test_name, got.lane, exp_q[idx].data, exp_q[idx].channel,
                         got.data, got.channel);
                test_errors++;
            end
            exp_q.delete(idx);
            pending--;
            words_seen++;
        end
        // the count of a lane only stops rising when it wraps
        if (cfg.enable && last_ok[got.lane] && got.data == WORD_W'(cfg.start_val)
            && got.data <= last_data[got.lane])
            wrapped[got.lane] = 1'b1;
        last_data[got.lane] = got.data;
        last_ok[got.lane] = 1'b1;
    endtask

    // msb comes first after a ws change and the bit taken with the change is the lsb
    task automatic sample_bit();
        logic slot_end;
        slot_end = ws_seen && (ws != ws_last);
        for (int i = 0; i < NUM_LANES; i++)
        begin
            if (bit_cnt < BITS_PER_CH)
                shift[i][WORD_W - 1 - bit_cnt] = sd[i];
            if (slot_end && cfg.enable)
                push_word(WORD_W'(cnt), ws_last, i);
            else if (slot_end && framed)
                push_word(shift[i], ws_last, i);
            if (slot_end)
                shift[i] = '0;
        end
        if (slot_end)
        begin
            if (cfg.enable && int'(cnt) + int'(cfg.inc) > int'(cfg.up_limit))
                cnt = cfg.start_val;            // wrap
            else if (cfg.enable)
                cnt = cnt + CNT_W'(cfg.inc);
            framed = 1'b1;
            bit_cnt = 0;
        end
        else if (bit_cnt < BITS_PER_CH)
            bit_cnt++;
        ws_last = ws;
        ws_seen = 1'b1;
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            if (out_xfc)
                note_failure("out_xfc went high during reset");
            sck_q = 1'b0;
            ws_last = 1'b0;
            ws_seen = 1'b0;
            framed = 1'b0;
            bit_cnt = 0;
            cnt = '0;
            for (int i = 0; i < NUM_LANES; i++)
                shift[i] = '0;
            exp_q.delete();
            pending = 0;
        end
        else
        begin
            if (out_xfc)
                check_word(out_word);
            if (!cfg.enable)
                cnt = cfg.start_val;            // held until test mode starts
            if (sck && !sck_q)
                sample_bit();
            sck_q = sck;
        end
    end

endmodule

// File: tb/i2si_tb.sv
module i2si_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import i2si_pkg::*;

    localparam int HALF_SCK = 6;                // sck half period in clk
    localparam logic [15:0] SEED = 16'd52;
    localparam int FRAMES = 8;                  // frames per test
    localparam int NUM_TESTS = 5;
    localparam int WATCHDOG_NS = NUM_TESTS * FRAMES * 64 * 12 * 4 * 2;

    logic                 clk;
    logic                 rst_n;
    logic                 sck;
    logic                 ws;
    logic [NUM_LANES-1:0] sd;
    bist_cfg_t            cfg;
    out_word_t            out_word;
    logic                 out_xfc;
    logic [15:0]          lfsr;

    i2si_top dut (.*);
    i2si_checker chk (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = {v[30:0], lfsr[15]};
        end
        return v;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // up_limit stays close enough above start_val to force a wrap
    task automatic random_cfg(output bist_cfg_t c);
        logic [31:0] v;
        int          span;
        c.enable = 1'b0;
        v = take_bits(11);
        c.start_val = CNT_W'(v);
        v = take_bits(8);
        c.inc = INC_W'(1 + v % 255);
        v = take_bits(12);
        span = int'(v) % (int'(c.inc) * 8);
        c.up_limit = c.start_val + CNT_W'(span);
    endtask

    task automatic set_cfg(input bist_cfg_t c);
        repeat (2) @(posedge clk);              // away from the last slot end
        cfg <= c;
    endtask

    // 64 bits per frame and ws flips with the lsb of each slot
    task automatic run_frames(input int frames);
        logic [31:0] bits;
        for (int f = 0; f < frames; f++)
        begin
            for (int n = 0; n < 64; n++)
            begin
                bits = take_bits(NUM_LANES);
                @(posedge clk);
                sck <= 1'b0;
                ws <= (n >= 31) && (n < 63);
                sd <= bits[NUM_LANES-1:0];
                repeat (HALF_SCK) @(posedge clk);
                sck <= 1'b1;                    // bit taken on this edge
                repeat (HALF_SCK - 1) @(posedge clk);
            end
        end
    endtask

    task automatic close_test();
        wait (chk.pending == 0);
        repeat (NUM_LANES + 2) @(posedge clk);  // room for a stray extra word
        chk.finish_test();
    endtask

    initial
    begin
        bist_cfg_t c;
        rst_n = 1'b1;
        sck = 1'b0;
        ws = 1'b0;
        sd = '0;
        cfg = '0;
        lfsr = SEED;
        c = '0;
        apply_reset();

        chk.begin_test("normal");
        run_frames(FRAMES);
        close_test();

        chk.begin_test("pattern");
        random_cfg(c);
        set_cfg(c);                             // new values while disabled
        c.enable = 1'b1;
        set_cfg(c);
        run_frames(FRAMES);
        if (chk.wrapped != '1)
            chk.note_failure("counter did not wrap to start_val on every lane");
        close_test();

        chk.begin_test("restart");
        run_frames(3);
        c.enable = 1'b0;
        set_cfg(c);
        run_frames(2);                          // serial data in between
        c.enable = 1'b1;
        set_cfg(c);
        run_frames(3);
        close_test();

        chk.begin_test("interleave");
        c.enable = 1'b0;
        set_cfg(c);
        run_frames(FRAMES);
        close_test();

        chk.begin_test("reset");
        apply_reset();
        run_frames(FRAMES);
        close_test();

        $display("summary: %0d tests run, %0d failed", chk.tests_run, chk.tests_failed);
        if (chk.tests_failed == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

endmodule
